//--- uart_alu.f
+incdir+src
src/uart_pkg.sv
src/alu_pkg.sv
src/uart_rx.sv
src/result_sender.sv
src/alu_core.sv
src/operand_sequencer.sv
src/uart_alu_top.sv
bench/tb_clock_gen.sv
bench/uart_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f uart_alu.f --top-module uart_alu_tb \
    -Mdir "$OBJ" -o uart_alu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/uart_alu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- bench/uart_alu_tb.sv
`timescale 1ns/10ps
`include "uart_alu_consts.svh"

module uart_alu_tb;

    // Each command is 5 frames in and 3 frames out
    localparam int NUM_COMMANDS   = 56;
    localparam int TIMEOUT_CYCLES = NUM_COMMANDS * 8 * `FRAME_BITS * `CLKS_PER_BIT + 2000;
    localparam int DRIVE_DELAY    = 2;

    logic        clk;
    logic        reset;
    logic        rx;
    logic        tx;
    logic        frame_error;
    logic [31:0] lcg_state;
    logic [7:0]  exp_q[$];
    logic [7:0]  got_q[$];
    int          sent_count = 0;
    int          checked_count = 0;
    int          fe_count = 0;
    event        byte_seen;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    uart_alu_top i_uart_alu_top (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .tx          (tx),
        .frame_error (frame_error)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // Returns {flags, result}
    function automatic logic [23:0] alu_model(input logic [15:0] a, input logic [15:0] b,
                                              input logic [7:0] cmd);
        logic [15:0] r;
        logic        carry;
        logic        inv;
        r     = 16'h0000;
        carry = 1'b0;
        inv   = 1'b0;
        case (cmd)
            8'h01: begin
                r     = a + b;
                carry = (r < a);
            end
            8'h02: begin
                r     = a - b;
                carry = (a < b);
            end
            8'h03: r = a & b;
            8'h04: r = a | b;
            8'h05: r = a ^ b;
            8'h06: r = a << b[3:0];
            8'h07: r = a >> b[3:0];
            default: inv = 1'b1;
        endcase
        return {4'b0000, inv, r[15], carry, (r == 16'h0000) && !inv, r};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string byte_name(input int position);
        case (position)
            0:       return "result[7:0]";
            1:       return "result[15:8]";
            default: return "flags";
        endcase
    endfunction

    task automatic next_random(output logic [15:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state[31:16];
    endtask

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Mismatch on %s: got 0x%h, expected 0x%h",
                                      name, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial driver
    ////////////////////////////////////////////////////////////////////////////

    // Start bit, eight data bits LSB first, then the given stop bit
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < `FRAME_BITS; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY) rx = frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic idle_bits(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY) rx = 1'b1;
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input logic [15:0] a, input logic [15:0] b,
                                input logic [7:0] cmd);
        logic [23:0] expect_word;
        expect_word = alu_model(a, b, cmd);
        exp_q.push_back(expect_word[7:0]);
        exp_q.push_back(expect_word[15:8]);
        exp_q.push_back(expect_word[23:16]);
        sent_count += `RESULT_BYTES;
        send_byte(a[7:0], 1'b1);
        send_byte(a[15:8], 1'b1);
        send_byte(b[7:0], 1'b1);
        send_byte(b[15:8], 1'b1);
        send_byte(cmd, 1'b1);
    endtask

    task automatic wait_responses();
        wait (checked_count == sent_count);
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor, checker, watchdog
    ////////////////////////////////////////////////////////////////////////////

    // Samples tx at bit centres on the falling clock edge
    initial begin : tx_monitor
        logic [7:0] data;
        @(negedge reset);
        forever begin
            @(negedge tx);
            repeat (`HALF_BIT) @(negedge clk);
            check_value("tx start bit", 16'(tx), 16'h0000);
            for (int i = 0; i < `DATA_BITS; i++) begin
                repeat (`CLKS_PER_BIT) @(negedge clk);
                data[i] = tx;
            end
            repeat (`CLKS_PER_BIT) @(negedge clk);
            check_value("tx stop bit", 16'(tx), 16'h0001);
            got_q.push_back(data);
            -> byte_seen;
        end
    end

    initial begin : compare_responses
        logic [7:0] actual;
        logic [7:0] expected;
        int         position;
        position = 0;
        forever begin
            @(byte_seen);
            while (got_q.size() > 0) begin
                actual = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    stop_on_failure($sformatf("Byte 0x%h came out on tx with no response pending",
                                              actual));
                end else begin
                    expected = exp_q.pop_front();
                    check_value(byte_name(position), 16'(actual), 16'(expected));
                    position = (position + 1) % `RESULT_BYTES;
                    checked_count++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && frame_error) begin
            fe_count++;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_on_failure($sformatf("Timeout, a response never arrived within %0d cycles",
                                  TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        int          fe_before;
        rx        = 1'b1;
        lcg_state = 32'h11a98f54;
        @(negedge reset);

        // Quiet line after reset
        repeat (3 * `CLKS_PER_BIT) begin
            @(negedge clk);
            check_value("tx", 16'(tx), 16'h0001);
            check_value("frame_error", 16'(frame_error), 16'h0000);
        end

        // Directed operands for every command
        send_command(16'h1234, 16'h4321, 8'h01);
        send_command(16'hFFFF, 16'h0001, 8'h01);
        send_command(16'h0000, 16'h0001, 8'h02);
        send_command(16'h5000, 16'h1000, 8'h02);
        send_command(16'hF0F0, 16'h3C3C, 8'h03);
        send_command(16'h0F00, 16'h00F0, 8'h04);
        send_command(16'hAAAA, 16'hAAAA, 8'h05);
        send_command(16'h0001, 16'h000F, 8'h06);
        send_command(16'h00FF, 16'hFFF4, 8'h06);
        send_command(16'h8000, 16'h0004, 8'h07);
        wait_responses();

        // Undefined command bytes
        send_command(16'h1111, 16'h2222, 8'h00);
        send_command(16'hFFFF, 16'h0001, 8'h80);
        wait_responses();

        for (int n = 0; n < 40; n++) begin
            next_random(a);
            next_random(b);
            next_random(r);
            send_command(a, b, 8'(r % 16'd7) + 8'd1);
        end
        wait_responses();

        // A byte with a low stop bit is not counted
        fe_before = fe_count;
        send_byte(8'hA5, 1'b0);
        idle_bits(2);
        check_value("frame_error count", 16'(fe_count), 16'(fe_before + 1));
        send_command(16'h0F0F, 16'h0101, 8'h01);
        wait_responses();

        // Next command goes out while the previous response is on tx
        send_command(16'h7FFF, 16'h0001, 8'h01);
        send_command(16'h1234, 16'h0003, 8'h07);
        send_command(16'hC3C3, 16'h0F0F, 8'h05);
        wait_responses();

        check_value("frame_error count", 16'(fe_count), 16'h0001);
        idle_bits(1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

//--- src/uart_alu_top.sv
`timescale 1ns/10ps

module uart_alu_top (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output logic frame_error
);
    import uart_pkg::*;

    logic  rx_valid;
    byte_t rx_data;

    operand_if opr_bus ();
    result_if  res_bus ();

    uart_rx i_uart_rx (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .frame_error (frame_error)
    );

    operand_sequencer i_operand_sequencer (
        .clk      (clk),
        .reset    (reset),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .opr      (opr_bus.source)
    );

    alu_core i_alu_core (
        .clk   (clk),
        .reset (reset),
        .opr   (opr_bus.sink),
        .res   (res_bus.source)
    );

    result_sender i_result_sender (
        .clk   (clk),
        .reset (reset),
        .res   (res_bus.sink),
        .tx    (tx)
    );

endmodule

//--- src/operand_sequencer.sv
`timescale 1ns/10ps
`include "uart_alu_consts.svh"

module operand_sequencer (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx_valid,
    input  uart_pkg::byte_t rx_data,
    operand_if.source       opr
);
    import alu_pkg::*;

    seq_state_t state;
    operand_t   stage_a;
    operand_t   stage_b;
    alu_cmd_t   stage_cmd;
    logic       last_byte;
    logic       hs_idle;
    logic       load_op;

    assign last_byte = (int'(state) == `CMD_BYTES - 1);
    assign hs_idle   = !opr.req && !opr.ack;

    // Issue on the command byte itself, or later from SEQ_ISSUE once free
    assign load_op = hs_idle && ((last_byte && rx_valid) || state == SEQ_ISSUE);

    ////////////////////////////////////////////////////////////////////////////
    // Byte counter and request
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SEQ_A_LO;
            opr.req <= 1'b0;
        end else begin
            if (load_op) begin
                opr.req <= 1'b1;
            end else if (opr.req && opr.ack) begin
                opr.req <= 1'b0;
            end

            case (state)
                SEQ_ISSUE: begin
                    // Count is full, bytes arriving now are dropped
                    if (hs_idle) begin
                        state <= SEQ_A_LO;
                    end
                end
                default: begin
                    if (rx_valid) begin
                        if (!last_byte) begin
                            state <= seq_state_t'(state + 1'b1);
                        end else if (hs_idle) begin
                            state <= SEQ_A_LO;
                        end else begin
                            state <= SEQ_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand assembly
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                SEQ_A_LO: stage_a[7:0]  <= rx_data;
                SEQ_A_HI: stage_a[15:8] <= rx_data;
                SEQ_B_LO: stage_b[7:0]  <= rx_data;
                SEQ_B_HI: stage_b[15:8] <= rx_data;
                SEQ_CMD:  stage_cmd     <= alu_cmd_t'(rx_data);
                default: ;
            endcase
        end
    end

    // Bus data only moves while req and ack are both low
    always_ff @(posedge clk) begin
        if (load_op) begin
            opr.op_a <= stage_a;
            opr.op_b <= stage_b;
            opr.cmd  <= (state == SEQ_ISSUE) ? stage_cmd : alu_cmd_t'(rx_data);
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (reset)
        (opr.req && !opr.ack) |=>
            ($stable(opr.op_a) && $stable(opr.op_b) && $stable(opr.cmd)));

endmodule

//--- src/alu_core.sv
`timescale 1ns/10ps

// Four-phase req/ack operand hand-off from the sequencer
interface operand_if;
    logic              req;
    logic              ack;
    alu_pkg::operand_t op_a;
    alu_pkg::operand_t op_b;
    alu_pkg::alu_cmd_t cmd;

    modport source (output req, output op_a, output op_b, output cmd, input ack);
    modport sink (input req, input op_a, input op_b, input cmd, output ack);
endinterface

module alu_core (
    input  logic      clk,
    input  logic      reset,
    operand_if.sink   opr,
    result_if.source  res
);
    import alu_pkg::*;

    logic [16:0] wide;
    result_t     alu_result;
    flags_t      alu_flags;
    logic        invalid;
    logic        accept;

    // 17 bits so the add carry and the subtract borrow land in bit 16
    always_comb begin
        wide    = '0;
        invalid = 1'b0;
        case (opr.cmd)
            CMD_ADD: wide = {1'b0, opr.op_a} + {1'b0, opr.op_b};
            CMD_SUB: wide = {1'b0, opr.op_a} - {1'b0, opr.op_b};
            CMD_AND: wide = {1'b0, opr.op_a & opr.op_b};
            CMD_OR:  wide = {1'b0, opr.op_a | opr.op_b};
            CMD_XOR: wide = {1'b0, opr.op_a ^ opr.op_b};
            CMD_SHL: wide = {1'b0, opr.op_a << opr.op_b[3:0]};
            CMD_SHR: wide = {1'b0, opr.op_a >> opr.op_b[3:0]};
            default: invalid = 1'b1;
        endcase
    end

    assign alu_result = wide[15:0];
    assign alu_flags  = {4'b0000, invalid, alu_result[15], wide[16],
                         (alu_result == '0) && !invalid};

    // New work only while the result path is completely idle
    assign accept = opr.req && !opr.ack && !res.req && !res.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            opr.ack <= 1'b0;
            res.req <= 1'b0;
        end else begin
            if (accept) begin
                opr.ack <= 1'b1;
            end else if (opr.ack && !opr.req) begin
                opr.ack <= 1'b0;
            end

            if (accept) begin
                res.req <= 1'b1;
            end else if (res.req && res.ack) begin
                res.req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res.result <= alu_result;
            res.flags  <= alu_flags;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(opr.ack) |-> opr.req);

endmodule

//--- src/result_sender.sv
`timescale 1ns/10ps
`include "uart_alu_consts.svh"

// Result hand-off to the transmitter, same four-phase rule as operand_if
interface result_if;
    logic             req;
    logic             ack;
    alu_pkg::result_t result;
    alu_pkg::flags_t  flags;

    modport source (output req, output result, output flags, input ack);
    modport sink (input req, input result, input flags, output ack);
endinterface

module result_sender (
    input  logic    clk,
    input  logic    reset,
    result_if.sink  res,
    output logic    tx
);
    import uart_pkg::*;
    import alu_pkg::*;

    tx_state_t  state;
    tick_cnt_t  tick;
    bit_idx_t   bit_idx;
    logic [1:0] byte_idx;
    result_t    held_result;
    flags_t     held_flags;
    byte_t      cur_byte;
    logic       tx_bit;
    logic       bit_done;
    logic       accept;

    assign accept   = (state == TX_IDLE) && res.req && !res.ack;
    assign bit_done = (tick == tick_cnt_t'(`CLKS_PER_BIT - 1));

    // Byte order on the line is low, high, flags
    always_comb begin
        case (byte_idx)
            2'd0:    cur_byte = held_result[7:0];
            2'd1:    cur_byte = held_result[15:8];
            default: cur_byte = held_flags;
        endcase
    end

    always_comb begin
        case (state)
            TX_START: tx_bit = 1'b0;
            TX_DATA:  tx_bit = cur_byte[bit_idx];
            default:  tx_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= TX_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            res.ack  <= 1'b0;
            tx       <= 1'b1;
        end else begin
            tx <= tx_bit;

            if (accept) begin
                res.ack <= 1'b1;
            end else if (res.ack && !res.req) begin
                res.ack <= 1'b0;
            end

            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        tick     <= '0;
                        byte_idx <= '0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_t'(`DATA_BITS - 1)) begin
                            state <= TX_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        tick <= '0;
                        // Next frame starts straight after this stop bit
                        if (byte_idx == 2'(`RESULT_BYTES - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= TX_START;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_result <= res.result;
            held_flags  <= res.flags;
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/10ps
`include "uart_alu_consts.svh"

module uart_rx (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output logic            rx_valid,
    output uart_pkg::byte_t rx_data,
    output logic            frame_error
);
    import uart_pkg::*;

    rx_state_t state;
    tick_cnt_t tick;
    bit_idx_t  bit_idx;
    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;
    logic      start_edge;
    logic      bit_done;

    assign start_edge = rx_prev && !rx_sync;
    assign bit_done   = (tick == tick_cnt_t'(`CLKS_PER_BIT - 1));

    // Two-stage synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RX_IDLE;
            tick        <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick == tick_cnt_t'(`HALF_BIT - 1)) begin
                        // Glitch if the line is high again at mid start bit
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_t'(`DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        tick        <= '0;
                        state       <= RX_IDLE;
                        rx_valid    <= rx_sync;
                        frame_error <= !rx_sync;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

    a_valid_xor_error: assert property (@(posedge clk) disable iff (reset)
        !(rx_valid && frame_error));

endmodule

//--- src/alu_pkg.sv
package alu_pkg;

    typedef logic [15:0] operand_t;
    typedef logic [15:0] result_t;

    // Bit 0 zero, bit 1 carry/borrow, bit 2 negative, bit 3 invalid command
    typedef logic [7:0] flags_t;

    typedef enum logic [7:0] {
        CMD_ADD = 8'h01,
        CMD_SUB = 8'h02,
        CMD_AND = 8'h03,
        CMD_OR  = 8'h04,
        CMD_XOR = 8'h05,
        CMD_SHL = 8'h06,
        CMD_SHR = 8'h07
    } alu_cmd_t;

    // One state per received byte, then the hand-off to the ALU
    typedef enum logic [2:0] {
        SEQ_A_LO, SEQ_A_HI, SEQ_B_LO, SEQ_B_HI, SEQ_CMD, SEQ_ISSUE
    } seq_state_t;

endpackage

//--- src/uart_pkg.sv
`include "uart_alu_consts.svh"

package uart_pkg;

    // One data byte on the serial line
    typedef logic [7:0] byte_t;

    // Clock ticks within one bit period
    typedef logic [$clog2(`CLKS_PER_BIT)-1:0] tick_cnt_t;

    // Data bit position within a frame
    typedef logic [$clog2(`DATA_BITS)-1:0] bit_idx_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

//--- src/uart_alu_consts.svh
`ifndef UART_ALU_CONSTS_SVH
`define UART_ALU_CONSTS_SVH

// Serial bit timing in clock cycles
`define CLKS_PER_BIT 16
`define HALF_BIT 8

// 8N1 frame layout
`define DATA_BITS 8
`define FRAME_BITS 10

// Message sizes in bytes
`define CMD_BYTES 5
`define RESULT_BYTES 3

`endif
